// ==== Bender.yml ====
package:
  name: pulseCompression

sources:
  - common/pulseCompressionPkg.sv
  - common/complexStream.sv
  - hw/pulseCompressionSequencer.sv
  - hilbertTransform/hilbertTransform.sv
  - matchedFilter/complexFir.sv
  - hw/magnitudeSqrt.sv
  - hw/pulseCompressionTop.sv
  - target: simulation
    files:
      - verification/pulseCompression_asserts.sv
      - verification/pulseCompressionTb.sv

// ==== common/complexStream.sv ====
// No back-pressure: a sink must take every beat that has valid high.
`timescale 1ns/1ps

// One complex sample stream between two internal blocks.
// The component type is a parameter, so the same interface carries both
// the 24-bit analytic signal and the 42-bit filter output.
interface complexStream #(
	parameter type DataT = pulseCompressionPkg::AccT
);

	// A new sample is present on re and im while valid is high.
	logic valid;

	// Real and imaginary parts of the sample.
	DataT re;
	DataT im;

	// Tells the downstream block to zero its data history.
	// It is a single-cycle pulse and never comes with valid.
	logic flush;

	// The upstream block drives every signal.
	modport source (
		output valid,
		output re,
		output im,
		output flush
	);

	// The downstream block only reads.
	modport sink (
		input valid,
		input re,
		input im,
		input flush
	);

endinterface

// ==== common/pulseCompressionPkg.sv ====
// Widths assume 12-bit ADC samples and 12-bit reference parts; changing one means re-deriving the rest.
package pulseCompressionPkg;

	// Real ADC input samples, two's complement.
	localparam int sampleWidth = 12;
	typedef logic signed [sampleWidth-1:0] SampleT;

	// Hilbert FIR geometry.
	// Seven taps, centered on tap three, with zeros at even offsets from the center.
	localparam int htTaps = 7;
	localparam int htCenter = (htTaps - 1) / 2;
	localparam int htCoeffWidth = 12;

	// Ideal 2/(pi*n) response scaled by 2^11, antisymmetric about the center.
	// Index zero multiplies the newest sample.
	localparam logic signed [htCoeffWidth-1:0] hilbertCoeffs [htTaps] = '{
		-12'sd435,
		12'sd0,
		-12'sd1304,
		12'sd0,
		12'sd1304,
		12'sd0,
		12'sd435
	};

	// The center sample is shifted up by this amount so it sits on the coefficient scale.
	localparam int htShift = 11;

	// One component of the analytic signal.
	// The imaginary sum peaks near 7.1e6, which fits in 24 signed bits.
	localparam int analyticWidth = 24;
	typedef logic signed [analyticWidth-1:0] AnalyticT;

	// Matched filter reference pulse parts.
	localparam int coeffWidth = 12;
	typedef logic signed [coeffWidth-1:0] CoeffT;
	localparam int firTaps = 16;
	localparam int tapCountWidth = $clog2(firTaps);

	// Complex filter output component.
	localparam int accWidth = 42;
	typedef logic signed [accWidth-1:0] AccT;

	// Magnitude path widths.
	// The sum of two squares of a 42-bit value needs 84 bits, and its root needs 42.
	localparam int squareSumWidth = 2 * accWidth;
	typedef logic [squareSumWidth-1:0] SquareSumT;
	localparam int rootWidth = accWidth;
	typedef logic [rootWidth-1:0] RootT;

	// The top keeps the upper 32 root bits.
	localparam int magWidth = 32;
	typedef logic [magWidth-1:0] MagT;

	// Square root pipeline, six root bits per stage.
	localparam int sqrtStages = 7;
	localparam int rootBitsPerStage = rootWidth / sqrtStages;
	// The signed remainder needs two bits more than the root.
	localparam int sqrtRemWidth = rootWidth + 2;

	// Sequencer states.
	typedef enum logic [1:0] {
		Idle,
		LoadCoeff,
		Filter
	} SeqStateT;

endpackage

// ==== hilbertTransform/hilbertTransform.sv ====
// Fixed seven-tap response; the real output is the input delayed by three accepted samples.
`timescale 1ns/1ps

module hilbertTransform (
	input logic clock,
	input logic rstN,
	input logic sampleEnable,
	input logic flush,
	input pulseCompressionPkg::SampleT sample,
	complexStream.source analytic
);

	// Previous samples, with index zero holding the one accepted last.
	pulseCompressionPkg::SampleT history [pulseCompressionPkg::htTaps-1];

	// The full seven-sample window, with the incoming sample at index zero.
	pulseCompressionPkg::SampleT window [pulseCompressionPkg::htTaps];

	// Output values before the register.
	pulseCompressionPkg::AnalyticT realNext;
	pulseCompressionPkg::AnalyticT imagNext;

	// The window uses the new sample directly, so the result is ready one cycle later.
	always_comb begin
		window[0] = sample;
		for (int k = 1; k < pulseCompressionPkg::htTaps; k++) begin
			window[k] = history[k-1];
		end
	end

	// Imaginary part from the odd-offset taps.
	// Taps at even offsets from the center are zero, so only every other one is summed.
	// The real part is the center sample on the same scale as the coefficients.
	always_comb begin
		imagNext = '0;
		for (int k = 0; k < pulseCompressionPkg::htTaps; k += 2) begin
			imagNext = imagNext +
				pulseCompressionPkg::AnalyticT'(window[k]) *
				pulseCompressionPkg::AnalyticT'(pulseCompressionPkg::hilbertCoeffs[k]);
		end
		realNext = pulseCompressionPkg::AnalyticT'(window[pulseCompressionPkg::htCenter])
			<<< pulseCompressionPkg::htShift;
	end

	// Sample history.
	// A flush zeroes it so the next run starts from silence.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int k = 0; k < pulseCompressionPkg::htTaps - 1; k++) begin
				history[k] <= '0;
			end
		end else if (flush) begin
			for (int k = 0; k < pulseCompressionPkg::htTaps - 1; k++) begin
				history[k] <= '0;
			end
		end else if (sampleEnable) begin
			history[0] <= sample;
			for (int k = 1; k < pulseCompressionPkg::htTaps - 1; k++) begin
				history[k] <= history[k-1];
			end
		end
	end

	// Stream control. The flush goes on downstream one cycle later, alongside the data.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			analytic.valid <= 1'b0;
			analytic.flush <= 1'b0;
		end else begin
			analytic.valid <= sampleEnable;
			analytic.flush <= flush;
		end
	end

	// Output data only changes when a sample is accepted.
	always_ff @(posedge clock) begin
		if (sampleEnable) begin
			analytic.re <= realNext;
			analytic.im <= imagNext;
		end
	end

endmodule

// ==== hw/magnitudeSqrt.sv ====
// Floor root of re^2 + im^2; the last of the seven root stages drives the output without a register.
`timescale 1ns/1ps

module magnitudeSqrt (
	input logic clock,
	input logic rstN,
	complexStream.sink dataIn,
	output logic magValid,
	output pulseCompressionPkg::MagT magnitude
);

	// Signed partial remainder of the non-restoring algorithm.
	typedef logic signed [pulseCompressionPkg::sqrtRemWidth-1:0] RemT;

	// Everything one root stage hands to the next.
	// rad holds the radicand bits not yet consumed, aligned to the top.
	typedef struct packed {
		RemT rem;
		pulseCompressionPkg::RootT root;
		pulseCompressionPkg::SquareSumT rad;
	} RootStateT;

	// Stage registers. Index zero holds the freshly registered sum of squares.
	RootStateT pipe [pulseCompressionPkg::sqrtStages];
	RootStateT stepOut [pulseCompressionPkg::sqrtStages];
	logic [pulseCompressionPkg::sqrtStages-1:0] pipeValid;
	pulseCompressionPkg::SquareSumT squareSum;

	// Resolves six root bits, two radicand bits per iteration.
	// A non-negative remainder subtracts 4Q+1, a negative one adds 4Q+3.
	// The sign after each step gives the next root bit.
	function automatic RootStateT rootStep(input RootStateT cur);
		RootStateT nxt;
		RemT shifted;
		nxt = cur;
		for (int i = 0; i < pulseCompressionPkg::rootBitsPerStage; i++) begin
			shifted = {nxt.rem[pulseCompressionPkg::sqrtRemWidth-3:0],
				nxt.rad[pulseCompressionPkg::squareSumWidth-1 -: 2]};
			nxt.rad = nxt.rad << 2;
			if (!nxt.rem[pulseCompressionPkg::sqrtRemWidth-1]) begin
				nxt.rem = shifted - RemT'({nxt.root, 2'b01});
			end else begin
				nxt.rem = shifted + RemT'({nxt.root, 2'b11});
			end
			nxt.root = {nxt.root[pulseCompressionPkg::rootWidth-2:0],
				~nxt.rem[pulseCompressionPkg::sqrtRemWidth-1]};
		end
		return nxt;
	endfunction

	// Both squares are non-negative, and their sum fits the 84-bit width.
	assign squareSum = dataIn.re * dataIn.re + dataIn.im * dataIn.im;

	always_comb begin
		for (int s = 0; s < pulseCompressionPkg::sqrtStages; s++) begin
			stepOut[s] = rootStep(pipe[s]);
		end
	end

	// The data pipeline runs freely, and pipeValid marks the real results.
	always_ff @(posedge clock) begin
		pipe[0] <= '{rem: '0, root: '0, rad: squareSum};
		for (int s = 1; s < pulseCompressionPkg::sqrtStages; s++) begin
			pipe[s] <= stepOut[s-1];
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			pipeValid <= '0;
		end else begin
			pipeValid <= {pipeValid[pulseCompressionPkg::sqrtStages-2:0], dataIn.valid};
		end
	end

	// Keep the upper 32 root bits, as the output scaling expects.
	assign magValid = pipeValid[pulseCompressionPkg::sqrtStages-1];
	assign magnitude = stepOut[pulseCompressionPkg::sqrtStages-1].root[
		pulseCompressionPkg::rootWidth-1 -: pulseCompressionPkg::magWidth];

endmodule

// ==== hw/pulseCompressionSequencer.sv ====
// Takes exactly firTaps coefficient strobes after start; only clear restarts a load.
`timescale 1ns/1ps

module pulseCompressionSequencer (
	input logic clock,
	input logic rstN,
	input logic start,
	input logic clear,
	input logic coeffValid,
	input logic sampleValid,
	output logic coeffWrite,
	output logic sampleEnable,
	output logic flushHistory,
	output logic coeffLoaded
);

	// Current phase of operation.
	pulseCompressionPkg::SeqStateT state;

	// Number of coefficient pairs written so far in this load.
	logic [pulseCompressionPkg::tapCountWidth-1:0] tapCount;

	// The control strobes are combinational from the state.
	// A strobe that arrives in the wrong state is simply dropped.
	// clear overrides everything in the cycle it is high.
	always_comb begin
		flushHistory = clear;
		coeffWrite = coeffValid && !clear &&
			(state == pulseCompressionPkg::LoadCoeff);
		sampleEnable = sampleValid && !clear &&
			(state == pulseCompressionPkg::Filter);
		coeffLoaded = (state == pulseCompressionPkg::Filter);
	end

	// State register and tap counter.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			state <= pulseCompressionPkg::Idle;
			tapCount <= '0;
		end else if (clear) begin
			// clear aborts a load or a run and waits for the next start.
			state <= pulseCompressionPkg::Idle;
			tapCount <= '0;
		end else begin
			case (state)
				pulseCompressionPkg::Idle: begin
					if (start) begin
						state <= pulseCompressionPkg::LoadCoeff;
						tapCount <= '0;
					end
				end
				pulseCompressionPkg::LoadCoeff: begin
					if (coeffWrite) begin
						// The counter wraps to zero on the last pair.
						tapCount <= tapCount + 1'b1;
						if (tapCount == pulseCompressionPkg::tapCountWidth'(
								pulseCompressionPkg::firTaps - 1)) begin
							state <= pulseCompressionPkg::Filter;
						end
					end
				end
				pulseCompressionPkg::Filter: begin
					// Data flows until the next clear.
					state <= pulseCompressionPkg::Filter;
				end
				default: begin
					state <= pulseCompressionPkg::Idle;
				end
			endcase
		end
	end

endmodule

// ==== hw/pulseCompressionTop.sv ====
// magValid follows each accepted sample by nine cycles; there is no back-pressure on any input.
`timescale 1ns/1ps

module pulseCompressionTop (
	input logic clock,
	input logic rstN,
	input logic start,
	input logic clear,
	input logic coeffValid,
	input pulseCompressionPkg::CoeffT coeffRe,
	input pulseCompressionPkg::CoeffT coeffIm,
	input logic sampleValid,
	input pulseCompressionPkg::SampleT sample,
	output logic coeffLoaded,
	output logic magValid,
	output pulseCompressionPkg::MagT magnitude
);

	// Sequencer controls.
	logic coeffWrite;
	logic sampleEnable;
	logic flushHistory;

	// Analytic signal into the matched filter, then filter output into the magnitude.
	complexStream #(.DataT(pulseCompressionPkg::AnalyticT)) analyticLink ();
	complexStream #(.DataT(pulseCompressionPkg::AccT)) filteredLink ();

	// Loads coefficients first and then lets samples through.
	pulseCompressionSequencer sequencer (
		.clock(clock),
		.rstN(rstN),
		.start(start),
		.clear(clear),
		.coeffValid(coeffValid),
		.sampleValid(sampleValid),
		.coeffWrite(coeffWrite),
		.sampleEnable(sampleEnable),
		.flushHistory(flushHistory),
		.coeffLoaded(coeffLoaded)
	);

	// Real samples to the analytic signal. The flush also travels on to the matched filter.
	hilbertTransform hilbert (
		.clock(clock),
		.rstN(rstN),
		.sampleEnable(sampleEnable),
		.flush(flushHistory),
		.sample(sample),
		.analytic(analyticLink.source)
	);

	// Correlation with the reference pulse.
	complexFir matched (
		.clock(clock),
		.rstN(rstN),
		.coeffWrite(coeffWrite),
		.coeffRe(coeffRe),
		.coeffIm(coeffIm),
		.dataIn(analyticLink.sink),
		.dataOut(filteredLink.source)
	);

	// Magnitude of each filter output.
	magnitudeSqrt magnitudeCalc (
		.clock(clock),
		.rstN(rstN),
		.dataIn(filteredLink.sink),
		.magValid(magValid),
		.magnitude(magnitude)
	);

endmodule

// ==== matchedFilter/complexFir.sv ====
// Coefficients are not double-buffered; loading while samples flow mixes old and new taps.
`timescale 1ns/1ps

module complexFir (
	input logic clock,
	input logic rstN,
	input logic coeffWrite,
	input pulseCompressionPkg::CoeffT coeffRe,
	input pulseCompressionPkg::CoeffT coeffIm,
	complexStream.sink dataIn,
	complexStream.source dataOut
);

	// Coefficient shift line.
	// New pairs enter at index zero, so the first pair loaded ends up at the oldest tap.
	pulseCompressionPkg::CoeffT tapRe [pulseCompressionPkg::firTaps];
	pulseCompressionPkg::CoeffT tapIm [pulseCompressionPkg::firTaps];

	// Earlier input samples, newest at index zero.
	pulseCompressionPkg::AnalyticT histRe [pulseCompressionPkg::firTaps-1];
	pulseCompressionPkg::AnalyticT histIm [pulseCompressionPkg::firTaps-1];

	// Current input followed by the history.
	pulseCompressionPkg::AnalyticT winRe [pulseCompressionPkg::firTaps];
	pulseCompressionPkg::AnalyticT winIm [pulseCompressionPkg::firTaps];

	// Complex product sums before the output register.
	pulseCompressionPkg::AccT sumRe;
	pulseCompressionPkg::AccT sumIm;

	// Build the window from the live input and the stored history.
	always_comb begin
		winRe[0] = dataIn.re;
		winIm[0] = dataIn.im;
		for (int k = 1; k < pulseCompressionPkg::firTaps; k++) begin
			winRe[k] = histRe[k-1];
			winIm[k] = histIm[k-1];
		end
	end

	// Full complex multiply-accumulate in one cycle.
	// (a + jb)(c + jd) = (ac - bd) + j(ad + bc).
	always_comb begin
		sumRe = '0;
		sumIm = '0;
		for (int k = 0; k < pulseCompressionPkg::firTaps; k++) begin
			sumRe = sumRe
				+ pulseCompressionPkg::AccT'(winRe[k]) * pulseCompressionPkg::AccT'(tapRe[k])
				- pulseCompressionPkg::AccT'(winIm[k]) * pulseCompressionPkg::AccT'(tapIm[k]);
			sumIm = sumIm
				+ pulseCompressionPkg::AccT'(winRe[k]) * pulseCompressionPkg::AccT'(tapIm[k])
				+ pulseCompressionPkg::AccT'(winIm[k]) * pulseCompressionPkg::AccT'(tapRe[k]);
		end
	end

	// Coefficient line, written only while the sequencer is loading.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int k = 0; k < pulseCompressionPkg::firTaps; k++) begin
				tapRe[k] <= '0;
				tapIm[k] <= '0;
			end
		end else if (coeffWrite) begin
			tapRe[0] <= coeffRe;
			tapIm[0] <= coeffIm;
			for (int k = 1; k < pulseCompressionPkg::firTaps; k++) begin
				tapRe[k] <= tapRe[k-1];
				tapIm[k] <= tapIm[k-1];
			end
		end
	end

	// Data history. A flush from upstream takes priority over a sample.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int k = 0; k < pulseCompressionPkg::firTaps - 1; k++) begin
				histRe[k] <= '0;
				histIm[k] <= '0;
			end
		end else if (dataIn.flush) begin
			for (int k = 0; k < pulseCompressionPkg::firTaps - 1; k++) begin
				histRe[k] <= '0;
				histIm[k] <= '0;
			end
		end else if (dataIn.valid) begin
			histRe[0] <= dataIn.re;
			histIm[0] <= dataIn.im;
			for (int k = 1; k < pulseCompressionPkg::firTaps - 1; k++) begin
				histRe[k] <= histRe[k-1];
				histIm[k] <= histIm[k-1];
			end
		end
	end

	// One output per input sample, one cycle later.
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			dataOut.valid <= 1'b0;
		end else begin
			dataOut.valid <= dataIn.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (dataIn.valid) begin
			dataOut.re <= sumRe;
			dataOut.im <= sumIm;
		end
	end

	// Nothing further down keeps a history.
	assign dataOut.flush = 1'b0;

endmodule

// ==== sim.f ====
common/pulseCompressionPkg.sv
common/complexStream.sv
hw/pulseCompressionSequencer.sv
hilbertTransform/hilbertTransform.sv
matchedFilter/complexFir.sv
hw/magnitudeSqrt.sv
hw/pulseCompressionTop.sv
verification/pulseCompression_asserts.sv
verification/pulseCompressionTb.sv

// ==== verification/pulseCompressionTb.sv ====
// Outputs are sampled on the falling edge and matched in order; a result is due 9 cycles after its sample.
`timescale 1ns/1ps

module pulseCompressionTb;

	// DUT ports.
	logic clock;
	logic rstN;
	logic start;
	logic clear;
	logic coeffValid;
	pulseCompressionPkg::CoeffT coeffRe;
	pulseCompressionPkg::CoeffT coeffIm;
	logic sampleValid;
	pulseCompressionPkg::SampleT sample;
	logic coeffLoaded;
	logic magValid;
	pulseCompressionPkg::MagT magnitude;

	// Stimulus lengths. The watchdog budget is worked out from these.
	int resetCycles = 4;
	int idleCycles = 20;
	int gapSamples = 200;
	int burstSamples = 64;
	int reloadSamples = 100;
	integer seed = 76180;

	// Model of the sequencer, the two filter histories and the coefficient line.
	// Index zero is always the newest entry.
	pulseCompressionPkg::SeqStateT modelState;
	int modelCount;
	longint htHist [pulseCompressionPkg::htTaps];
	longint firRe [pulseCompressionPkg::firTaps];
	longint firIm [pulseCompressionPkg::firTaps];
	longint tapRe [pulseCompressionPkg::firTaps];
	longint tapIm [pulseCompressionPkg::firTaps];

	// Expected magnitudes, with the falling edge each one is due on.
	pulseCompressionPkg::MagT expMag [$];
	int expDue [$];
	int cycleCount;

	// Error counts, one per kind of check.
	int magErrors;
	int loadedErrors;
	int timingErrors;

	pulseCompressionTop uut (
		.clock(clock),
		.rstN(rstN),
		.start(start),
		.clear(clear),
		.coeffValid(coeffValid),
		.coeffRe(coeffRe),
		.coeffIm(coeffIm),
		.sampleValid(sampleValid),
		.sample(sample),
		.coeffLoaded(coeffLoaded),
		.magValid(magValid),
		.magnitude(magnitude)
	);

	// 4 ns clock period.
	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Returns true with the given probability in percent.
	function automatic logic chance(input int percent);
		int draw;
		draw = $random(seed) % 100;
		if (draw < 0) begin
			draw = -draw;
		end
		return draw < percent;
	endfunction

	// Floor square root, one bit at a time from the top.
	function automatic logic [63:0] floorSqrt(input logic [127:0] value);
		logic [63:0] root;
		logic [63:0] trial;
		root = '0;
		for (int b = 63; b >= 0; b--) begin
			trial = root | (64'd1 << b);
			if ({64'd0, trial} * {64'd0, trial} <= value) begin
				root = trial;
			end
		end
		return root;
	endfunction

	task automatic checkMagnitude(input pulseCompressionPkg::MagT actual,
		input pulseCompressionPkg::MagT expected);
		if (actual !== expected) begin
			$display("** Error @ %0t: magnitude = %0d, expected %0d", $time, actual, expected);
			magErrors++;
		end
	endtask

	task automatic checkLoaded(input logic actual, input logic expected);
		if (actual !== expected) begin
			$display("** Error @ %0t: coeffLoaded = %b, expected %b", $time, actual, expected);
			loadedErrors++;
		end
	endtask

	// Both data histories go back to silence, as after a clear.
	task automatic zeroHistories();
		for (int k = 0; k < pulseCompressionPkg::htTaps; k++) begin
			htHist[k] = 0;
		end
		for (int k = 0; k < pulseCompressionPkg::firTaps; k++) begin
			firRe[k] = 0;
			firIm[k] = 0;
		end
	endtask

	// The first pair loaded drifts out to the oldest tap.
	task automatic acceptCoeff(input pulseCompressionPkg::CoeffT re,
		input pulseCompressionPkg::CoeffT im);
		for (int k = pulseCompressionPkg::firTaps - 1; k > 0; k--) begin
			tapRe[k] = tapRe[k-1];
			tapIm[k] = tapIm[k-1];
		end
		tapRe[0] = re;
		tapIm[0] = im;
	endtask

	// Runs one real sample through the whole chain and queues its magnitude.
	task automatic acceptSample(input pulseCompressionPkg::SampleT s);
		longint hRe;
		longint hIm;
		longint yRe;
		longint yIm;
		logic signed [127:0] wideRe;
		logic signed [127:0] wideIm;
		logic [127:0] power;
		logic [63:0] root;
		for (int k = pulseCompressionPkg::htTaps - 1; k > 0; k--) begin
			htHist[k] = htHist[k-1];
		end
		htHist[0] = s;
		// The real part is the center sample lifted onto the coefficient scale.
		hRe = htHist[pulseCompressionPkg::htCenter] <<< pulseCompressionPkg::htShift;
		hIm = 0;
		for (int k = 0; k < pulseCompressionPkg::htTaps; k++) begin
			hIm += htHist[k] * pulseCompressionPkg::hilbertCoeffs[k];
		end
		for (int k = pulseCompressionPkg::firTaps - 1; k > 0; k--) begin
			firRe[k] = firRe[k-1];
			firIm[k] = firIm[k-1];
		end
		firRe[0] = hRe;
		firIm[0] = hIm;
		yRe = 0;
		yIm = 0;
		for (int k = 0; k < pulseCompressionPkg::firTaps; k++) begin
			yRe += firRe[k] * tapRe[k] - firIm[k] * tapIm[k];
			yIm += firRe[k] * tapIm[k] + firIm[k] * tapRe[k];
		end
		// Squares of 42-bit values overflow 64 bits.
		wideRe = yRe;
		wideIm = yIm;
		power = wideRe * wideRe + wideIm * wideIm;
		root = floorSqrt(power);
		expMag.push_back(pulseCompressionPkg::MagT'(
			root >> (pulseCompressionPkg::rootWidth - pulseCompressionPkg::magWidth)));
		expDue.push_back(cycleCount + 9);
	endtask

	// Looks at the outputs on the falling edge, where they are settled.
	task automatic checkOutputs();
		checkLoaded(coeffLoaded, modelState == pulseCompressionPkg::Filter);
		if (magValid) begin
			if (expMag.size() == 0) begin
				$display("Magnitude came out at %0t with no sample pending", $time);
				timingErrors++;
			end else begin
				if (expDue[0] != cycleCount) begin
					$display("Magnitude at %0t came in cycle %0d but was due in cycle %0d",
						$time, cycleCount, expDue[0]);
					timingErrors++;
				end
				checkMagnitude(magnitude, expMag[0]);
				void'(expMag.pop_front());
				void'(expDue.pop_front());
			end
		end else if (expDue.size() > 0 && expDue[0] <= cycleCount) begin
			$display("No magnitude at %0t for the result due in cycle %0d", $time, expDue[0]);
			timingErrors++;
			void'(expMag.pop_front());
			void'(expDue.pop_front());
		end
	endtask

	// Drives one cycle from a falling edge, steps the model, then checks at the next falling edge.
	task automatic applyCycle(input logic startPulse, input logic clearPulse,
		input logic coeffStrobe, input logic sampleStrobe);
		start = startPulse;
		clear = clearPulse;
		coeffValid = coeffStrobe;
		coeffRe = pulseCompressionPkg::CoeffT'($random(seed));
		coeffIm = pulseCompressionPkg::CoeffT'($random(seed));
		sampleValid = sampleStrobe;
		sample = pulseCompressionPkg::SampleT'($random(seed));
		if (clearPulse) begin
			modelState = pulseCompressionPkg::Idle;
			modelCount = 0;
			zeroHistories();
		end else begin
			case (modelState)
				pulseCompressionPkg::Idle: begin
					if (startPulse) begin
						modelState = pulseCompressionPkg::LoadCoeff;
						modelCount = 0;
					end
				end
				pulseCompressionPkg::LoadCoeff: begin
					if (coeffStrobe) begin
						acceptCoeff(coeffRe, coeffIm);
						modelCount++;
						if (modelCount == pulseCompressionPkg::firTaps) begin
							modelState = pulseCompressionPkg::Filter;
						end
					end
				end
				default: begin
					if (sampleStrobe) begin
						acceptSample(sample);
					end
				end
			endcase
		end
		@(negedge clock);
		cycleCount++;
		checkOutputs();
	endtask

	// Start, then random coefficient strobes until 16 are taken.
	// Samples thrown in during the load must be dropped.
	task automatic loadCoefficients();
		applyCycle(1'b1, 1'b0, 1'b0, 1'b0);
		while (modelState != pulseCompressionPkg::Filter) begin
			applyCycle(1'b0, 1'b0, chance(70), chance(30));
		end
	endtask

	// Stray coefficient strobes here are ignored by the sequencer.
	task automatic runSamples(input int count, input int percent);
		int sent;
		logic fire;
		sent = 0;
		while (sent < count) begin
			fire = chance(percent);
			applyCycle(1'b0, 1'b0, chance(10), fire);
			if (fire) begin
				sent++;
			end
		end
	endtask

	task automatic drainResults();
		while (expMag.size() > 0) begin
			applyCycle(1'b0, 1'b0, 1'b0, 1'b0);
		end
	endtask

	initial begin
		rstN = 1'b1;
		start = 1'b0;
		clear = 1'b0;
		coeffValid = 1'b0;
		coeffRe = '0;
		coeffIm = '0;
		sampleValid = 1'b0;
		sample = '0;
		modelState = pulseCompressionPkg::Idle;
		modelCount = 0;
		cycleCount = 0;
		magErrors = 0;
		loadedErrors = 0;
		timingErrors = 0;
		zeroHistories();
		for (int k = 0; k < pulseCompressionPkg::firTaps; k++) begin
			tapRe[k] = 0;
			tapIm[k] = 0;
		end
		#1 rstN = 1'b0;
		repeat (resetCycles) @(negedge clock);
		rstN = 1'b1;
		// Strobes before start must not reach the output.
		repeat (idleCycles) applyCycle(1'b0, 1'b0, chance(50), chance(50));
		loadCoefficients();
		// One extra coefficient once the line is full.
		applyCycle(1'b0, 1'b0, 1'b1, 1'b0);
		runSamples(gapSamples, 40);
		runSamples(burstSamples, 100);
		// Clear with results still in flight, then reload from empty histories.
		applyCycle(1'b0, 1'b1, 1'b0, 1'b0);
		drainResults();
		loadCoefficients();
		runSamples(reloadSamples, 50);
		runSamples(burstSamples, 100);
		drainResults();
		$display("Errors: magnitude %0d, coeffLoaded %0d, timing %0d, assertions %0d",
			magErrors, loadedErrors, timingErrors, uut.strobeChecks.failures);
		if (magErrors + loadedErrors + timingErrors + uut.strobeChecks.failures == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Generous bound on every phase, with each sample allowed five cycles.
	initial begin
		repeat (resetCycles + idleCycles + 10 * pulseCompressionPkg::firTaps
			+ 5 * (gapSamples + reloadSamples) + 2 * burstSamples + 200) @(posedge clock);
		$display("Watchdog expired in cycle %0d with %0d results still pending",
			cycleCount, expMag.size());
		$display("Finished with errors");
		$finish;
	end

endmodule

// ==== verification/pulseCompression_asserts.sv ====
// Bound into the top level; reads the sequencer state through a hierarchical connection.
`timescale 1ns/1ps

module pulseCompression_asserts (
	input logic clock,
	input logic rstN,
	input logic sampleEnable,
	input logic magValid,
	input pulseCompressionPkg::SeqStateT state
);

	// Number of failed assertions, added into the testbench summary.
	int failures = 0;

	// The result pipeline is empty while reset is held.
	magLowInReset: assert property (@(posedge clock) !rstN |-> !magValid)
		else begin
			$error("magValid high during reset");
			failures++;
		end

	// The state register holds one of the three legal encodings.
	stateLegal: assert property (@(posedge clock) disable iff (!rstN)
		state inside {pulseCompressionPkg::Idle, pulseCompressionPkg::LoadCoeff,
			pulseCompressionPkg::Filter})
		else begin
			$error("sequencer state outside the enum");
			failures++;
		end

	// Every accepted sample gives one result exactly nine cycles later.
	resultLatency: assert property (@(posedge clock) disable iff (!rstN)
		sampleEnable |-> ##9 magValid)
		else begin
			$error("magValid missing nine cycles after sampleEnable");
			failures++;
		end

endmodule

bind pulseCompressionTop pulseCompression_asserts strobeChecks (
	.clock(clock),
	.rstN(rstN),
	.sampleEnable(sampleEnable),
	.magValid(magValid),
	.state(sequencer.state)
);
